//--- verilog.f
+incdir+include
design/ecd_pkg.sv
design/ppb_reg_file.sv
design/burst_addr_gen.sv
design/fetch_ctrl.sv
design/ecd_master_ctrl.sv
testbench/tb_ecd_master_ctrl.sv

//--- Bender.yml
package:
  name: ecd_master_ctrl

sources:
  # RTL in compile order
  - files:
      - design/ecd_pkg.sv
      - design/ppb_reg_file.sv
      - design/burst_addr_gen.sv
      - design/fetch_ctrl.sv
      - design/ecd_master_ctrl.sv

  # Testbench, top module tb_ecd_master_ctrl
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/tb_ecd_master_ctrl.sv

//--- include/ecd_tb_util.svh
`ifndef ECD_TB_UTIL_SVH
`define ECD_TB_UTIL_SVH

// Failures seen by access checks and by assertions
int check_errors = 0;
int assert_errors = 0;

// Galois LFSR state behind all random stimulus
logic [31:0] lfsr_state = 32'h7337;

// One random bit per call, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return lsb;
endfunction

// Compare and report one value
task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
        $display("Fail %s expected %h actual %h", name, exp, act);
        check_errors++;
    end
endtask

// Strobe a write, response is sampled one cycle after the strobe
task automatic reg_write_word(input logic [31:0] addr, input logic [31:0] data,
                              output ecd_pkg::resp_t resp);
    @(posedge clk);
    reg_write <= 1'b1;
    reg_waddr <= addr;
    reg_wdata <= data;
    @(posedge clk);
    reg_write <= 1'b0;
    @(posedge clk);
    resp = reg_wresp;
endtask

// Strobe a read, data and response come back one cycle later
task automatic reg_read_word(input logic [31:0] addr, output logic [31:0] data,
                             output ecd_pkg::resp_t resp);
    @(posedge clk);
    reg_read  <= 1'b1;
    reg_raddr <= addr;
    @(posedge clk);
    reg_read <= 1'b0;
    @(posedge clk);
    data = reg_rdata;
    resp = reg_rresp;
endtask

`endif

//--- testbench/tb_ecd_master_ctrl.sv
module tb_ecd_master_ctrl;

    // ======================================================================
    // Run length
    // ======================================================================
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 2;
    localparam int TEST1_CYCLES = 200;
    localparam int TEST2_CYCLES = 100;
    localparam int TEST3_CYCLES = 300;
    localparam int TEST4_CYCLES = 500;
    // Test 4 waits once for buffer 1 and once more for the refill
    localparam int TOTAL_CYCLES = RESET_CYCLES + TEST1_CYCLES + TEST2_CYCLES
                                + TEST3_CYCLES + 2 * TEST4_CYCLES;
    // Extra cycles on top of the test budgets
    localparam int WATCHDOG_TIME = (TOTAL_CYCLES + 200) * CLK_PERIOD;

    // Clock and reset
    logic clk    = 1'b0;
    logic resetn = 1'b0;

    // Register access port
    logic               reg_write = 1'b0;
    ecd_pkg::reg_word_t reg_waddr = '0;
    ecd_pkg::reg_word_t reg_wdata = '0;
    ecd_pkg::resp_t     reg_wresp;
    logic               reg_read  = 1'b0;
    ecd_pkg::reg_word_t reg_raddr = '0;
    ecd_pkg::reg_word_t reg_rdata;
    ecd_pkg::resp_t     reg_rresp;

    // AR channel
    ecd_pkg::axi_addr_t araddr;
    logic               arvalid;
    logic [7:0]         arlen;
    logic [2:0]         arsize;
    logic [1:0]         arburst;
    logic               arready = 1'b0;

    // R channel and stream output
    ecd_pkg::axi_data_t rdata  = '0;
    logic               rvalid = 1'b0;
    logic               rready;
    ecd_pkg::axi_data_t tdata;
    logic               tvalid;
    logic               tready = 1'b0;

    // Buffer setup as the host programs it
    ecd_pkg::axi_addr_t ppb0_cfg   = 64'h0000_0001_2000_0000;
    ecd_pkg::axi_addr_t ppb1_cfg   = 64'h0000_0001_2040_0000;
    int                 blocks_cfg = 3;

    // Address model state
    logic               exp_buf;
    int                 xfer_count;
    int                 bursts_accepted;
    ecd_pkg::axi_addr_t exp_addr;

    // High while no AR request may appear
    logic expect_idle = 1'b0;

    `include "ecd_tb_util.svh"

    ecd_master_ctrl uut (
        .clk       (clk),
        .resetn    (resetn),
        .reg_write (reg_write),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wresp (reg_wresp),
        .reg_read  (reg_read),
        .reg_raddr (reg_raddr),
        .reg_rdata (reg_rdata),
        .reg_rresp (reg_rresp),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arlen     (arlen),
        .arsize    (arsize),
        .arburst   (arburst),
        .arready   (arready),
        .rdata     (rdata),
        .rvalid    (rvalid),
        .rready    (rready),
        .tdata     (tdata),
        .tvalid    (tvalid),
        .tready    (tready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Byte address of a register word index
    function automatic ecd_pkg::reg_word_t word_addr(input logic [4:0] idx);
        return 32'(idx) << 2;
    endfunction

    // Stream order is the R beat with byte 0 and byte 63 swapped and so on
    function automatic ecd_pkg::axi_data_t byte_reverse(input ecd_pkg::axi_data_t d);
        return {<<8{d}};
    endfunction

    // One LFSR step per data bit
    function automatic ecd_pkg::axi_data_t random_data();
        ecd_pkg::axi_data_t d;
        for (int i = 0; i < ecd_pkg::AXI_DATA_WIDTH; i++) begin
            d[i] = lfsr_bit();
        end
        return d;
    endfunction

    // ======================================================================
    // Random slave and sink
    // ======================================================================
    always @(posedge clk) begin
        arready <= lfsr_bit();
        rvalid  <= lfsr_bit();
        tready  <= lfsr_bit();
        rdata   <= random_data();
    end

    // ======================================================================
    // Reference address model
    // ======================================================================
    // Buffer base plus one 2 KB step per accepted burst
    assign exp_addr = (exp_buf ? ppb1_cfg : ppb0_cfg)
                    + ecd_pkg::axi_addr_t'(xfer_count) * 64'd2048;

    always @(posedge clk) begin
        if (!resetn) begin
            exp_buf         <= 1'b0;
            xfer_count      <= 0;
            bursts_accepted <= 0;
        end else if (arvalid && arready) begin
            bursts_accepted <= bursts_accepted + 1;
            // Last block of a buffer moves the model to the other one
            if (xfer_count == blocks_cfg - 1) begin
                xfer_count <= 0;
                exp_buf    <= ~exp_buf;
            end else begin
                xfer_count <= xfer_count + 1;
            end
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================
    ar_addr_match: assert property (@(posedge clk) disable iff (!resetn)
        (arvalid && arready) |-> (araddr == exp_addr))
    else begin
        $display("Fail ar_addr expected %h actual %h", $sampled(exp_addr), $sampled(araddr));
        assert_errors++;
    end

    ar_fields_fixed: assert property (@(posedge clk) disable iff (!resetn)
        (arlen == 8'd31) && (arsize == 3'd6) && (arburst == 2'd1))
    else begin
        $display("Fail ar_fields expected 1f 6 1 actual %h %h %h",
                 $sampled(arlen), $sampled(arsize), $sampled(arburst));
        assert_errors++;
    end

    // Request and address hold until the slave takes them
    ar_request_hold: assert property (@(posedge clk) disable iff (!resetn)
        (arvalid && !arready) |=> (arvalid && $stable(araddr)))
    else begin
        $display("arvalid dropped or araddr moved before arready was seen");
        assert_errors++;
    end

    ar_stays_idle: assert property (@(posedge clk) disable iff (!resetn)
        expect_idle |-> !arvalid)
    else begin
        $display("arvalid rose while neither buffer was ready");
        assert_errors++;
    end

    stream_data_reversed: assert property (@(posedge clk)
        tdata == byte_reverse(rdata))
    else begin
        $display("Fail stream_tdata expected %h actual %h",
                 byte_reverse($sampled(rdata)), $sampled(tdata));
        assert_errors++;
    end

    stream_valid_follows: assert property (@(posedge clk) tvalid == rvalid)
    else begin
        $display("Fail stream_tvalid expected %b actual %b", $sampled(rvalid), $sampled(tvalid));
        assert_errors++;
    end

    stream_ready_follows: assert property (@(posedge clk) rready == tready)
    else begin
        $display("Fail stream_rready expected %b actual %b", $sampled(tready), $sampled(rready));
        assert_errors++;
    end

    // ======================================================================
    // Test helpers
    // ======================================================================
    task automatic write_and_check(input string name, input ecd_pkg::reg_word_t addr,
                                   input ecd_pkg::reg_word_t data);
        ecd_pkg::resp_t resp;
        reg_write_word(addr, data, resp);
        check_value({name, "_wresp"}, 64'(ecd_pkg::RESP_OKAY), 64'(resp));
    endtask

    task automatic read_and_check(input string name, input ecd_pkg::reg_word_t addr,
                                  input ecd_pkg::reg_word_t exp_data);
        ecd_pkg::reg_word_t data;
        ecd_pkg::resp_t     resp;
        reg_read_word(addr, data, resp);
        check_value({name, "_rdata"}, 64'(exp_data), 64'(data));
        check_value({name, "_rresp"}, 64'(ecd_pkg::RESP_OKAY), 64'(resp));
    endtask

    // Wait for the model to count a number of AR transfers
    task automatic wait_bursts(input string name, input int target, input int budget);
        int n;
        n = 0;
        while ((bursts_accepted < target) && (n < budget)) begin
            @(posedge clk);
            n++;
        end
        if (bursts_accepted < target) begin
            $display("%s timed out with %0d of %0d bursts accepted",
                     name, bursts_accepted, target);
            check_errors++;
        end
    endtask

    // ======================================================================
    // Watchdog
    // ======================================================================
    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        ecd_pkg::reg_word_t data;
        ecd_pkg::resp_t     resp;

        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        check_value("reset_arvalid", 64'd0, 64'(arvalid));

        // Reset defaults and then written values
        read_and_check("dflt_ppb0h", word_addr(ecd_pkg::REG_PPB0H), 32'h0);
        read_and_check("dflt_ppb0l", word_addr(ecd_pkg::REG_PPB0L), 32'hC000_0000);
        read_and_check("dflt_ppb1h", word_addr(ecd_pkg::REG_PPB1H), 32'h0);
        read_and_check("dflt_ppb1l", word_addr(ecd_pkg::REG_PPB1L), 32'hC001_0000);
        read_and_check("dflt_size", word_addr(ecd_pkg::REG_PPB_SIZE), 32'd32);
        write_and_check("wr_ppb0h", word_addr(ecd_pkg::REG_PPB0H), ppb0_cfg[63:32]);
        write_and_check("wr_ppb0l", word_addr(ecd_pkg::REG_PPB0L), ppb0_cfg[31:0]);
        write_and_check("wr_ppb1h", word_addr(ecd_pkg::REG_PPB1H), ppb1_cfg[63:32]);
        write_and_check("wr_ppb1l", word_addr(ecd_pkg::REG_PPB1L), ppb1_cfg[31:0]);
        write_and_check("wr_size", word_addr(ecd_pkg::REG_PPB_SIZE), 32'(blocks_cfg));
        read_and_check("rb_ppb0h", word_addr(ecd_pkg::REG_PPB0H), ppb0_cfg[63:32]);
        read_and_check("rb_ppb0l", word_addr(ecd_pkg::REG_PPB0L), ppb0_cfg[31:0]);
        read_and_check("rb_ppb1h", word_addr(ecd_pkg::REG_PPB1H), ppb1_cfg[63:32]);
        read_and_check("rb_ppb1l", word_addr(ecd_pkg::REG_PPB1L), ppb1_cfg[31:0]);
        read_and_check("rb_size", word_addr(ecd_pkg::REG_PPB_SIZE), 32'(blocks_cfg));

        // Unmapped and write-only indexes
        reg_read_word(word_addr(5'd5), data, resp);
        check_value("rd_idx5_rresp", 64'(ecd_pkg::RESP_DECERR), 64'(resp));
        reg_read_word(word_addr(5'd20), data, resp);
        check_value("rd_idx20_rresp", 64'(ecd_pkg::RESP_DECERR), 64'(resp));
        reg_read_word(word_addr(ecd_pkg::REG_START), data, resp);
        check_value("rd_start_rresp", 64'(ecd_pkg::RESP_DECERR), 64'(resp));
        reg_write_word(word_addr(5'd5), 32'hA5A5_A5A5, resp);
        check_value("wr_idx5_wresp", 64'(ecd_pkg::RESP_DECERR), 64'(resp));
        reg_write_word(word_addr(5'd20), 32'h5A5A_5A5A, resp);
        check_value("wr_idx20_wresp", 64'(ecd_pkg::RESP_DECERR), 64'(resp));
        write_and_check("wr_rdy3", word_addr(ecd_pkg::REG_PPB_RDY), 32'd3);
        read_and_check("rb_rdy3", word_addr(ecd_pkg::REG_PPB_RDY), 32'd3);

        // Buffer 0 walk with addresses checked by the model
        write_and_check("wr_start", word_addr(ecd_pkg::REG_START), 32'd1);
        wait_bursts("buffer0_walk", blocks_cfg, TEST3_CYCLES);

        // Buffer 1 follows while the buffer 0 flag is already clear
        reg_read_word(word_addr(ecd_pkg::REG_PPB_RDY), data, resp);
        check_value("rdy_bit0_clear", 64'd0, 64'(data[0]));
        wait_bursts("buffer1_walk", 2 * blocks_cfg, TEST4_CYCLES);

        // Both flags clear so no request until a refill
        expect_idle = 1'b1;
        repeat (20) @(posedge clk);
        read_and_check("rdy_both_clear", word_addr(ecd_pkg::REG_PPB_RDY), 32'd0);
        expect_idle = 1'b0;
        write_and_check("wr_rdy1", word_addr(ecd_pkg::REG_PPB_RDY), 32'd1);
        wait_bursts("buffer0_refill", 3 * blocks_cfg, TEST4_CYCLES);
        repeat (4) @(posedge clk);

        $display("Errors: %0d check, %0d assertion", check_errors, assert_errors);
        if ((check_errors == 0) && (assert_errors == 0)) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- design/ecd_master_ctrl.sv
module ecd_master_ctrl (
    input  logic               clk,
    input  logic               resetn,

    // Register access port
    input  logic               reg_write,
    input  ecd_pkg::reg_word_t reg_waddr,
    input  ecd_pkg::reg_word_t reg_wdata,
    output ecd_pkg::resp_t     reg_wresp,
    input  logic               reg_read,
    input  ecd_pkg::reg_word_t reg_raddr,
    output ecd_pkg::reg_word_t reg_rdata,
    output ecd_pkg::resp_t     reg_rresp,

    // AXI master AR channel
    output ecd_pkg::axi_addr_t araddr,
    output logic               arvalid,
    output logic [7:0]         arlen,
    output logic [2:0]         arsize,
    output logic [1:0]         arburst,
    input  logic               arready,

    // AXI master R channel
    input  ecd_pkg::axi_data_t rdata,
    input  logic               rvalid,
    output logic               rready,

    // AXI-Stream output
    output ecd_pkg::axi_data_t tdata,
    output logic               tvalid,
    input  logic               tready
);

    // Register file to FSM and generator
    logic               start_pulse;
    logic [1:0]         ppb_set;
    logic [1:0]         ppb_ready;
    ecd_pkg::axi_addr_t ppb0_base;
    ecd_pkg::axi_addr_t ppb1_base;
    ecd_pkg::reg_word_t ppb_blocks;

    // FSM to generator
    logic load;
    logic buffer_sel;
    logic advance;
    logic last_block;

    // ======================================================================
    // Configuration registers
    // ======================================================================
    ppb_reg_file u_reg_file (
        .clk         (clk),
        .resetn      (resetn),
        .reg_write   (reg_write),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .reg_wresp   (reg_wresp),
        .reg_read    (reg_read),
        .reg_raddr   (reg_raddr),
        .reg_rdata   (reg_rdata),
        .reg_rresp   (reg_rresp),
        .ppb_ready   (ppb_ready),
        .start_pulse (start_pulse),
        .ppb_set     (ppb_set),
        .ppb0_base   (ppb0_base),
        .ppb1_base   (ppb1_base),
        .ppb_blocks  (ppb_blocks)
    );

    // ======================================================================
    // Read request path
    // ======================================================================
    fetch_ctrl u_fetch_ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .start_pulse (start_pulse),
        .ppb_set     (ppb_set),
        .arready     (arready),
        .arvalid     (arvalid),
        .ppb_ready   (ppb_ready),
        .buffer_sel  (buffer_sel),
        .load        (load),
        .advance     (advance),
        .last_block  (last_block)
    );

    burst_addr_gen u_addr_gen (
        .clk        (clk),
        .resetn     (resetn),
        .load       (load),
        .buffer_sel (buffer_sel),
        .advance    (advance),
        .ppb0_base  (ppb0_base),
        .ppb1_base  (ppb1_base),
        .ppb_blocks (ppb_blocks),
        .araddr     (araddr),
        .last_block (last_block)
    );

    // Every burst has the same shape
    assign arlen   = ecd_pkg::BURST_LEN;
    assign arsize  = ecd_pkg::BURST_SIZE;
    assign arburst = ecd_pkg::BURST_INCR;

    // ======================================================================
    // Stream path
    // ======================================================================
    // Handshake passes straight through
    assign tvalid = rvalid;
    assign rready = tready;

    // Bridge delivers bytes little-endian, so flip them back
    for (genvar k = 0; k < ecd_pkg::AXI_DATA_BYTES; k++) begin : g_byte_swap
        assign tdata[k*8 +: 8] = rdata[(ecd_pkg::AXI_DATA_BYTES-1-k)*8 +: 8];
    end

endmodule

//--- design/fetch_ctrl.sv
module fetch_ctrl (
    input  logic       clk,
    input  logic       resetn,

    // Commands from the register file
    input  logic       start_pulse,
    input  logic [1:0] ppb_set,

    // AR handshake
    input  logic       arready,
    output logic       arvalid,

    // Buffer state, also read back by the host
    output logic [1:0] ppb_ready,
    output logic       buffer_sel,

    // Address generator control
    output logic       load,
    output logic       advance,
    input  logic       last_block
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_REQ
    } state_t;

    state_t     state;
    logic       buffer_done;
    logic [1:0] ready_next;

    // AR transfer on this edge
    assign advance = arvalid && arready;

    // Selected buffer has data, so kick off its first request
    assign load = (state == ST_WAIT) && ppb_ready[buffer_sel];

    // Final burst of the active buffer accepted
    assign buffer_done = advance && last_block;

    // ======================================================================
    // Ready flags
    // ======================================================================
    always_comb begin
        ready_next = ppb_ready;
        // Finished buffer goes back to the host
        if (buffer_done) begin
            ready_next[buffer_sel] = 1'b0;
        end
        // Start treats both buffers as loaded
        if ((state == ST_IDLE) && start_pulse) begin
            ready_next = 2'b11;
        end
        // A host refill wins over a clear on the same edge
        ready_next = ready_next | ppb_set;
    end

    // ======================================================================
    // Request FSM
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= ST_IDLE;
            arvalid    <= 1'b0;
            ppb_ready  <= 2'b00;
            buffer_sel <= 1'b0;
        end else begin
            ppb_ready <= ready_next;
            case (state)
                ST_IDLE: begin
                    if (start_pulse) begin
                        buffer_sel <= 1'b0;
                        state      <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    // Address is loaded on this same edge
                    if (load) begin
                        arvalid <= 1'b1;
                        state   <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    // Non-last bursts keep arvalid high while the address steps
                    if (buffer_done) begin
                        arvalid    <= 1'b0;
                        buffer_sel <= ~buffer_sel;
                        state      <= ST_WAIT;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // AR request is held until the slave takes it
    a_arvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
        (arvalid && !arready) |=> arvalid);

endmodule

//--- design/burst_addr_gen.sv
module burst_addr_gen (
    input  logic               clk,
    input  logic               resetn,

    // Control from the fetch FSM
    input  logic               load,
    input  logic               buffer_sel,
    input  logic               advance,

    // Buffer geometry from the register file
    input  ecd_pkg::axi_addr_t ppb0_base,
    input  ecd_pkg::axi_addr_t ppb1_base,
    input  ecd_pkg::reg_word_t ppb_blocks,

    // Current burst address on the AR channel
    output ecd_pkg::axi_addr_t araddr,
    output logic               last_block
);

    // Blocks still to be requested from the active buffer
    ecd_pkg::reg_word_t blocks_left;

    // ======================================================================
    // Address and block counter
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            blocks_left <= '0;
        end else if (load) begin
            blocks_left <= ppb_blocks;
        end else if (advance) begin
            blocks_left <= blocks_left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        // Start of the selected buffer
        if (load) begin
            araddr <= buffer_sel ? ppb1_base : ppb0_base;
        // Step one 2 KB block once the request is taken
        end else if (advance) begin
            araddr <= araddr + ecd_pkg::AXI_ADDR_WIDTH'(ecd_pkg::BYTES_PER_BURST);
        end
    end

    // One block left means the current request is the buffer's last
    assign last_block = (blocks_left == 32'd1);

    // The FSM must not accept a burst past the end of the buffer
    a_no_underflow: assert property (@(posedge clk) disable iff (!resetn)
        advance |-> (blocks_left != '0));

endmodule

//--- design/ppb_reg_file.sv
module ppb_reg_file (
    input  logic              clk,
    input  logic              resetn,

    // Host write strobe with address and data
    input  logic              reg_write,
    input  ecd_pkg::reg_word_t reg_waddr,
    input  ecd_pkg::reg_word_t reg_wdata,
    output ecd_pkg::resp_t    reg_wresp,

    // Host read strobe with address
    input  logic              reg_read,
    input  ecd_pkg::reg_word_t reg_raddr,
    output ecd_pkg::reg_word_t reg_rdata,
    output ecd_pkg::resp_t    reg_rresp,

    // Buffer flags from the fetch FSM, read-back only
    input  logic [1:0]        ppb_ready,

    // Commands to the fetch FSM
    output logic              start_pulse,
    output logic [1:0]        ppb_set,

    // Buffer geometry for the address generator
    output ecd_pkg::axi_addr_t ppb0_base,
    output ecd_pkg::axi_addr_t ppb1_base,
    output ecd_pkg::reg_word_t ppb_blocks
);

    // Storage registers
    ecd_pkg::reg_word_t ppb0_hi;
    ecd_pkg::reg_word_t ppb0_lo;
    ecd_pkg::reg_word_t ppb1_hi;
    ecd_pkg::reg_word_t ppb1_lo;
    ecd_pkg::reg_word_t ppb_size;

    // Word indexes after masking to the register window
    logic [4:0] widx;
    logic [4:0] ridx;

    assign widx = 5'((reg_waddr & ecd_pkg::REG_ADDR_MASK) >> 2);
    assign ridx = 5'((reg_raddr & ecd_pkg::REG_ADDR_MASK) >> 2);

    assign ppb0_base  = {ppb0_hi, ppb0_lo};
    assign ppb1_base  = {ppb1_hi, ppb1_lo};
    assign ppb_blocks = ppb_size;

    // ======================================================================
    // Write side
    // ======================================================================
    always_ff @(posedge clk) begin
        // Command outputs are single-cycle pulses
        start_pulse <= 1'b0;
        ppb_set     <= 2'b00;

        if (!resetn) begin
            ppb0_hi  <= ecd_pkg::PPB0_BASE_RESET[63:32];
            ppb0_lo  <= ecd_pkg::PPB0_BASE_RESET[31:0];
            ppb1_hi  <= ecd_pkg::PPB1_BASE_RESET[63:32];
            ppb1_lo  <= ecd_pkg::PPB1_BASE_RESET[31:0];
            ppb_size <= ecd_pkg::PPB_SIZE_RESET;
        end else if (reg_write) begin
            reg_wresp <= ecd_pkg::RESP_OKAY;
            case (widx)
                ecd_pkg::REG_PPB0H:    ppb0_hi  <= reg_wdata;
                ecd_pkg::REG_PPB0L:    ppb0_lo  <= reg_wdata;
                ecd_pkg::REG_PPB1H:    ppb1_hi  <= reg_wdata;
                ecd_pkg::REG_PPB1L:    ppb1_lo  <= reg_wdata;
                ecd_pkg::REG_PPB_SIZE: ppb_size <= reg_wdata;
                ecd_pkg::REG_START:    start_pulse <= 1'b1;
                // Each set bit marks that buffer as loaded
                ecd_pkg::REG_PPB_RDY:  ppb_set <= reg_wdata[1:0];
                default:               reg_wresp <= ecd_pkg::RESP_DECERR;
            endcase
        end
    end

    // ======================================================================
    // Read side
    // ======================================================================
    always_ff @(posedge clk) begin
        if (reg_read) begin
            reg_rresp <= ecd_pkg::RESP_OKAY;
            case (ridx)
                ecd_pkg::REG_PPB0H:    reg_rdata <= ppb0_hi;
                ecd_pkg::REG_PPB0L:    reg_rdata <= ppb0_lo;
                ecd_pkg::REG_PPB1H:    reg_rdata <= ppb1_hi;
                ecd_pkg::REG_PPB1L:    reg_rdata <= ppb1_lo;
                ecd_pkg::REG_PPB_SIZE: reg_rdata <= ppb_size;
                ecd_pkg::REG_PPB_RDY:  reg_rdata <= {30'd0, ppb_ready};
                // START is write-only, so it falls in here too
                default: begin
                    reg_rdata <= '0;
                    reg_rresp <= ecd_pkg::RESP_DECERR;
                end
            endcase
        end
    end

    // Start is a lone pulse per command
    a_start_single: assert property (@(posedge clk) disable iff (!resetn)
        start_pulse |=> !start_pulse);

    // Buffer-ready pulses only ever follow a host write
    a_set_after_write: assert property (@(posedge clk) disable iff (!resetn)
        !reg_write |=> (ppb_set == 2'b00));

endmodule

//--- design/ecd_pkg.sv
package ecd_pkg;

    // ======================================================================
    // Bus widths
    // ======================================================================
    localparam int AXI_ADDR_WIDTH = 64;
    localparam int AXI_DATA_WIDTH = 512;
    localparam int AXI_DATA_BYTES = AXI_DATA_WIDTH / 8;

    typedef logic [31:0]               reg_word_t;
    typedef logic [1:0]                resp_t;
    typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;

    // ======================================================================
    // Burst geometry
    // ======================================================================
    localparam int BEATS_PER_BURST = 32;
    // Address step from one burst to the next
    localparam int BYTES_PER_BURST = AXI_DATA_BYTES * BEATS_PER_BURST;

    // Fixed AR fields, 32 beats of 64 bytes, INCR
    localparam logic [7:0] BURST_LEN  = 8'(BEATS_PER_BURST - 1);
    localparam logic [2:0] BURST_SIZE = 3'd6;
    localparam logic [1:0] BURST_INCR = 2'd1;

    // ======================================================================
    // Register map
    // ======================================================================
    // Register window is 128 bytes, 32 words
    localparam logic [6:0] REG_ADDR_MASK = 7'h7F;

    localparam logic [4:0] REG_PPB0H    = 5'd0;
    localparam logic [4:0] REG_PPB0L    = 5'd1;
    localparam logic [4:0] REG_PPB1H    = 5'd2;
    localparam logic [4:0] REG_PPB1L    = 5'd3;
    localparam logic [4:0] REG_PPB_SIZE = 5'd4;
    localparam logic [4:0] REG_START    = 5'd10;
    localparam logic [4:0] REG_PPB_RDY  = 5'd11;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    // Values the storage registers come out of reset with
    localparam axi_addr_t PPB0_BASE_RESET = 64'h0000_0000_C000_0000;
    localparam axi_addr_t PPB1_BASE_RESET = 64'h0000_0000_C001_0000;
    localparam reg_word_t PPB_SIZE_RESET  = 32'd32;

endpackage
